// File: list.f
hdl/uart_frame_pkg.sv
hdl/apb_map_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_frame_ctrl.sv
hdl/uart_frame_regs.sv
hdl/uart_frame_top.sv
bench/tb_uart_frame.sv

// File: Bender.yml
package:
  name: uart_frame

sources:
  - hdl/uart_frame_pkg.sv
  - hdl/apb_map_pkg.sv
  - hdl/uart_tx.sv
  - hdl/uart_rx.sv
  - hdl/uart_frame_ctrl.sv
  - hdl/uart_frame_regs.sv
  - hdl/uart_frame_top.sv
  - target: simulation
    files:
      - bench/tb_uart_frame.sv

// File: bench/tb_uart_frame.sv
/*
 * tb_uart_frame
 * self-checking testbench of the framed uart transceiver
 * apb driver, rx line driver, tx line monitor comparing against frame_of
 */
`timescale 1ns/1ps
module tb_uart_frame;

	localparam CLKS_PER_BIT = 8;
	localparam MAX_LEN = 16;
	localparam N_TX_FRAMES = 6;
	localparam BUSY_LEN = 4;
	localparam POLL_LIMIT = 1000;
	// tx frames, busy frame, two good rx frames, then the three bad rx frames
	localparam WD_BYTES = (N_TX_FRAMES + 3) * (MAX_LEN + 4) + (MAX_LEN + 5) + 6 + 4;
	localparam WD_CYCLES = WD_BYTES * 10 * CLKS_PER_BIT * 2;

	typedef logic [7:0] byte_q_t[$];

	logic sys_clk;
	logic sys_rst_n;
	logic [apb_map_pkg::ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	wire [31:0] prdata;
	wire pready;
	wire pslverr;
	logic uart_rx_port;
	wire uart_tx_port;

	logic [31:0] rnd_state;
	logic last_err;
	byte_q_t exp_q;
	logic [7:0] mon_byte;
	int mon_bit;
	int mon_cnt;

	uart_frame_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.MAX_LEN (MAX_LEN)
	) dut (
		.sys_clk (sys_clk),
		.sys_rst_n (sys_rst_n),
		.paddr (paddr),
		.psel (psel),
		.penable (penable),
		.pwrite (pwrite),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr (pslverr),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial sys_clk = 1'b0;
	always #50 sys_clk = ~sys_clk;

	task automatic end_with_failure();
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
			end_with_failure();
		end
	endtask

	// LCG with the numerical recipes constants
	function automatic logic [31:0] next_rand();
		rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
		return rnd_state;
	endfunction

	// printable ascii other than the delimiter
	function automatic logic [7:0] rand_char();
		logic [31:0] r;
		logic [7:0] c;
		r = next_rand();
		c = 8'h20 + 8'(r[23:16] % 95);
		if (c == uart_frame_pkg::DELIM)
			c = 8'h2a;
		return c;
	endfunction

	function automatic byte_q_t make_payload(input int len);
		byte_q_t p;
		p = {};
		for (int k = 0; k < len; k++)
			p.push_back(rand_char());
		return p;
	endfunction

	function automatic int rand_len();
		logic [31:0] r;
		r = next_rand();
		return 1 + int'(r[27:20] % MAX_LEN);
	endfunction

	// expected line bytes with a delimiter pair on each side of the payload
	function automatic byte_q_t frame_of(input byte_q_t payload);
		byte_q_t f;
		f = {};
		f.push_back(uart_frame_pkg::DELIM);
		f.push_back(uart_frame_pkg::DELIM);
		foreach (payload[k])
			f.push_back(payload[k]);
		f.push_back(uart_frame_pkg::DELIM);
		f.push_back(uart_frame_pkg::DELIM);
		return f;
	endfunction

	// setup cycle, access cycle, then one idle cycle
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		@(negedge sys_clk);
		paddr = addr;
		pwrite = wr;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge sys_clk);
		penable = 1'b1;
		@(posedge sys_clk);
		check_eq("pready", pready, 1);
		rdata = prdata;
		last_err = pslverr;
		@(negedge sys_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic wr_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, data, unused);
	endtask

	task automatic rd_reg(input logic [7:0] addr, output logic [31:0] data);
		apb_xfer(1'b0, addr, 32'd0, data);
	endtask

	task automatic wait_status(input int pos, input logic level, input string what);
		logic [31:0] st;
		int n;
		n = 0;
		rd_reg(apb_map_pkg::STATUS_OFS, st);
		while (st[pos] !== level) begin
			n++;
			if (n == POLL_LIMIT) begin
				$display("%s did not happen within %0d status reads", what, POLL_LIMIT);
				end_with_failure();
			end
			rd_reg(apb_map_pkg::STATUS_OFS, st);
		end
	endtask

	task automatic start_tx(input byte_q_t payload);
		logic [31:0] st;
		foreach (payload[k])
			wr_reg(apb_map_pkg::TX_BUF_OFS + 8'(4 * k), {24'd0, payload[k]});
		wr_reg(apb_map_pkg::TX_LEN_OFS, payload.size());
		exp_q = frame_of(payload);
		mon_cnt = 0;
		wr_reg(apb_map_pkg::CTRL_OFS, 32'h1);
		rd_reg(apb_map_pkg::STATUS_OFS, st);
		check_eq("STATUS tx_busy after start", st[apb_map_pkg::ST_TX_BUSY], 1);
	endtask

	// 8N1 byte sent LSB first on falling edges
	task automatic send_byte(input logic [7:0] b);
		uart_rx_port = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		for (int k = 0; k < uart_frame_pkg::DATA_BITS; k++) begin
			uart_rx_port = b[k];
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
		end
		uart_rx_port = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
	endtask

	task automatic drive_line(input byte_q_t bytes);
		@(negedge sys_clk);
		foreach (bytes[k])
			send_byte(bytes[k]);
	endtask

	task automatic check_rx_frame(input byte_q_t payload);
		logic [31:0] rd;
		wait_status(apb_map_pkg::ST_RX_READY, 1'b1, "rx_ready");
		rd_reg(apb_map_pkg::STATUS_OFS, rd);
		check_eq("STATUS after good frame", rd, 32'(1) << apb_map_pkg::ST_RX_READY);
		rd_reg(apb_map_pkg::RX_LEN_OFS, rd);
		check_eq("RX_LEN", rd, payload.size());
		foreach (payload[k]) begin
			rd_reg(apb_map_pkg::RX_BUF_OFS + 8'(4 * k), rd);
			check_eq("RX_BUF", rd, {24'd0, payload[k]});
		end
		wr_reg(apb_map_pkg::STATUS_OFS, 32'(1) << apb_map_pkg::ST_RX_READY);
		rd_reg(apb_map_pkg::STATUS_OFS, rd);
		check_eq("STATUS after rx_ready clear", rd, 0);
	endtask

	task automatic check_rx_error(input byte_q_t bytes);
		logic [31:0] rd;
		drive_line(bytes);
		wait_status(apb_map_pkg::ST_RX_ERR, 1'b1, "rx_err");
		rd_reg(apb_map_pkg::STATUS_OFS, rd);
		check_eq("STATUS after bad frame", rd, 32'(1) << apb_map_pkg::ST_RX_ERR);
		wr_reg(apb_map_pkg::STATUS_OFS, 32'(1) << apb_map_pkg::ST_RX_ERR);
		rd_reg(apb_map_pkg::STATUS_OFS, rd);
		check_eq("STATUS after rx_err clear", rd, 0);
	endtask

	// tx line decoder checking each byte against the head of exp_q
	always begin
		wait (sys_rst_n === 1'b1);
		@(negedge uart_tx_port);
		repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
		if (uart_tx_port !== 1'b0) begin
			$display("start bit on uart_tx_port did not hold low to mid-bit");
			end_with_failure();
		end
		for (mon_bit = 0; mon_bit < uart_frame_pkg::DATA_BITS; mon_bit++) begin
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
			mon_byte[mon_bit] = uart_tx_port;
		end
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		if (uart_tx_port !== 1'b1) begin
			$display("stop bit on uart_tx_port was low");
			end_with_failure();
		end
		if (exp_q.size() == 0) begin
			$display("uart_tx_port sent a byte when no frame was expected");
			end_with_failure();
		end
		check_eq("uart_tx_port byte", mon_byte, exp_q.pop_front());
		mon_cnt++;
	end

	initial begin
		repeat (WD_CYCLES) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
		end_with_failure();
	end

	initial begin
		logic [31:0] rd;
		byte_q_t pl;
		sys_rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = 32'd0;
		uart_rx_port = 1'b1;
		rnd_state = 32'h787d165f;
		last_err = 1'b0;
		mon_cnt = 0;
		exp_q = {};
		repeat (5) @(negedge sys_clk);
		sys_rst_n = 1'b1;

		// register access and clamping of TX_LEN
		wr_reg(apb_map_pkg::TX_LEN_OFS, 32'd5);
		rd_reg(apb_map_pkg::TX_LEN_OFS, rd);
		check_eq("TX_LEN", rd, 5);
		check_eq("pslverr on TX_LEN", last_err, 0);
		wr_reg(apb_map_pkg::TX_LEN_OFS, 32'd0);
		rd_reg(apb_map_pkg::TX_LEN_OFS, rd);
		check_eq("TX_LEN after 0", rd, 1);
		wr_reg(apb_map_pkg::TX_LEN_OFS, 32'd40);
		rd_reg(apb_map_pkg::TX_LEN_OFS, rd);
		check_eq("TX_LEN after 40", rd, MAX_LEN);
		for (int k = 0; k < MAX_LEN; k++)
			wr_reg(apb_map_pkg::TX_BUF_OFS + 8'(4 * k), (apb_map_pkg::TX_BUF_OFS + 4 * k) ^ 8'hc3);
		for (int k = 0; k < MAX_LEN; k++) begin
			rd_reg(apb_map_pkg::TX_BUF_OFS + 8'(4 * k), rd);
			check_eq("TX_BUF", rd, 8'((apb_map_pkg::TX_BUF_OFS + 4 * k) ^ 8'hc3));
		end
		rd_reg(8'h10, rd);
		check_eq("pslverr at 0x10", last_err, 1);
		rd_reg(8'h41, rd);
		check_eq("pslverr at 0x41", last_err, 1);
		rd_reg(apb_map_pkg::RX_BUF_OFS + 8'(4 * MAX_LEN), rd);
		check_eq("pslverr past RX_BUF", last_err, 1);

		// transmit framing
		for (int f = 0; f < N_TX_FRAMES; f++) begin
			pl = make_payload(rand_len());
			start_tx(pl);
			wait_status(apb_map_pkg::ST_TX_BUSY, 1'b0, "end of tx frame");
			check_eq("tx bytes still missing", exp_q.size(), 0);
		end

		// a second start during a frame is dropped
		pl = make_payload(BUSY_LEN);
		start_tx(pl);
		wr_reg(apb_map_pkg::CTRL_OFS, 32'h1);
		wait_status(apb_map_pkg::ST_TX_BUSY, 1'b0, "end of busy tx frame");
		repeat (3 * 10 * CLKS_PER_BIT) @(negedge sys_clk);
		check_eq("tx bytes after busy start", mon_cnt, BUSY_LEN + 4);
		rd_reg(apb_map_pkg::STATUS_OFS, rd);
		check_eq("STATUS after busy start", rd, 0);

		// receive framing
		pl = make_payload(rand_len());
		drive_line(frame_of(pl));
		check_rx_frame(pl);

		// receive errors from overrun, lone delimiter and empty frame
		check_rx_error(frame_of(make_payload(MAX_LEN + 1)));
		check_rx_error({8'h26, 8'h26, 8'h61, 8'h62, 8'h26, 8'h78});
		check_rx_error({8'h26, 8'h26, 8'h26, 8'h26});

		pl = make_payload(rand_len());
		drive_line(frame_of(pl));
		check_rx_frame(pl);

		$display("TEST OK");
		$finish;
	end

endmodule

// File: hdl/uart_frame_top.sv
/*
 * framed string transceiver top
 * apb register block, frame controller and the two 8N1 serializers
 */
`timescale 1ns/1ps
module uart_frame_top #(
	parameter CLKS_PER_BIT = 868,
	parameter MAX_LEN = 16
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire [apb_map_pkg::ADDR_W-1:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [31:0] pwdata,
	output wire [31:0] prdata,
	output wire pready,
	output wire pslverr,
	input wire uart_rx_port,
	output wire uart_tx_port
);

	localparam LEN_W = $clog2(MAX_LEN + 1);
	localparam IDX_W = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1;

	// register block <-> frame controller
	wire tx_start;
	wire [LEN_W-1:0] tx_len;
	wire [IDX_W-1:0] tx_index;
	wire [7:0] tx_byte;
	wire tx_busy;
	wire rx_we;
	wire [IDX_W-1:0] rx_index;
	wire [7:0] rx_byte;
	wire [LEN_W-1:0] rx_len;
	wire rx_frame_done;
	wire rx_frame_err;

	// frame controller <-> serializers
	wire byte_req;
	wire [7:0] byte_data;
	wire byte_done;
	wire byte_vld;
	wire [7:0] byte_out;

	uart_frame_regs #(
		.MAX_LEN (MAX_LEN)
	) u_regs (
		.sys_clk (sys_clk),
		.sys_rst_n (sys_rst_n),
		.paddr (paddr),
		.psel (psel),
		.penable (penable),
		.pwrite (pwrite),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr (pslverr),
		.tx_start (tx_start),
		.tx_len (tx_len),
		.tx_index (tx_index),
		.tx_byte (tx_byte),
		.tx_busy (tx_busy),
		.rx_we (rx_we),
		.rx_index (rx_index),
		.rx_byte (rx_byte),
		.rx_len (rx_len),
		.rx_frame_done (rx_frame_done),
		.rx_frame_err (rx_frame_err)
	);

	uart_frame_ctrl #(
		.MAX_LEN (MAX_LEN)
	) u_ctrl (
		.sys_clk (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_start (tx_start),
		.tx_len (tx_len),
		.tx_index (tx_index),
		.tx_byte (tx_byte),
		.tx_busy (tx_busy),
		.byte_req (byte_req),
		.byte_data (byte_data),
		.byte_done (byte_done),
		.byte_vld (byte_vld),
		.byte_out (byte_out),
		.rx_we (rx_we),
		.rx_index (rx_index),
		.rx_byte (rx_byte),
		.rx_len (rx_len),
		.rx_frame_done (rx_frame_done),
		.rx_frame_err (rx_frame_err)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_tx (
		.sys_clk (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_req (byte_req),
		.byte_data (byte_data),
		.line (uart_tx_port),
		.byte_done (byte_done)
	);

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_rx (
		.sys_clk (sys_clk),
		.sys_rst_n (sys_rst_n),
		.line (uart_rx_port),
		.byte_out (byte_out),
		.byte_vld (byte_vld)
	);

endmodule

// File: hdl/uart_frame_regs.sv
/*
 * apb register block of the frame transceiver
 * control, sticky status, lengths, tx and rx payload buffers
 */
`timescale 1ns/1ps
module uart_frame_regs #(
	parameter MAX_LEN = 16,
	localparam LEN_W = $clog2(MAX_LEN + 1),
	localparam IDX_W = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire [apb_map_pkg::ADDR_W-1:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [31:0] pwdata,
	output reg [31:0] prdata,
	output wire pready,
	output wire pslverr,
	output reg tx_start,
	output reg [LEN_W-1:0] tx_len,
	input wire [IDX_W-1:0] tx_index,
	output wire [7:0] tx_byte,
	input wire tx_busy,
	input wire rx_we,
	input wire [IDX_W-1:0] rx_index,
	input wire [7:0] rx_byte,
	input wire [LEN_W-1:0] rx_len,
	input wire rx_frame_done,
	input wire rx_frame_err
);

	// bytes covered by the valid part of a buffer window
	localparam BUF_SPAN = 4 * MAX_LEN;

	reg [7:0] tx_buf [MAX_LEN];
	reg [7:0] rx_buf [MAX_LEN];
	reg rx_ready;
	reg rx_err;
	reg [LEN_W-1:0] rx_len_q;

	wire access = psel && penable;
	wire wr = access && pwrite;
	wire aligned = (paddr[1:0] == 2'b00);
	wire [apb_map_pkg::ADDR_W-1:0] tx_rel = paddr - apb_map_pkg::TX_BUF_OFS;
	wire [apb_map_pkg::ADDR_W-1:0] rx_rel = paddr - apb_map_pkg::RX_BUF_OFS;
	wire [IDX_W-1:0] tx_widx = tx_rel[IDX_W+1:2];
	wire [IDX_W-1:0] rx_ridx = rx_rel[IDX_W+1:2];
	wire ctrl_hit = (paddr == apb_map_pkg::CTRL_OFS);
	wire status_hit = (paddr == apb_map_pkg::STATUS_OFS);
	wire txlen_hit = (paddr == apb_map_pkg::TX_LEN_OFS);
	wire rxlen_hit = (paddr == apb_map_pkg::RX_LEN_OFS);
	wire tx_hit = aligned && (paddr >= apb_map_pkg::TX_BUF_OFS) && (tx_rel < BUF_SPAN);
	wire rx_hit = aligned && (paddr >= apb_map_pkg::RX_BUF_OFS) && (rx_rel < BUF_SPAN);
	wire mapped = ctrl_hit || status_hit || txlen_hit || rxlen_hit || tx_hit || rx_hit;

	assign pready = 1'b1;
	assign pslverr = access && !mapped;
	assign tx_byte = tx_buf[tx_index];

	always @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_start <= 1'b0;
			tx_len <= LEN_W'(1);
			rx_ready <= 1'b0;
			rx_err <= 1'b0;
			rx_len_q <= '0;
		end else begin
			// start is dropped while a frame is going out
			tx_start <= wr && ctrl_hit && pwdata[0] && !tx_busy;
			if (wr && txlen_hit) begin
				if (pwdata == 32'd0)
					tx_len <= LEN_W'(1);
				else if (pwdata > MAX_LEN)
					tx_len <= LEN_W'(MAX_LEN);
				else
					tx_len <= pwdata[LEN_W-1:0];
			end
			// a new event wins over a clear in the same cycle
			if (rx_frame_done)
				rx_ready <= 1'b1;
			else if (wr && status_hit && pwdata[apb_map_pkg::ST_RX_READY])
				rx_ready <= 1'b0;
			if (rx_frame_err)
				rx_err <= 1'b1;
			else if (wr && status_hit && pwdata[apb_map_pkg::ST_RX_ERR])
				rx_err <= 1'b0;
			if (rx_frame_done)
				rx_len_q <= rx_len;
		end
	end

	always @(posedge sys_clk) begin
		if (wr && tx_hit)
			tx_buf[tx_widx] <= pwdata[7:0];
		if (rx_we)
			rx_buf[rx_index] <= rx_byte;
	end

	// CTRL reads as zero
	always @(*) begin
		prdata = 32'd0;
		if (status_hit) begin
			prdata[apb_map_pkg::ST_TX_BUSY] = tx_busy;
			prdata[apb_map_pkg::ST_RX_READY] = rx_ready;
			prdata[apb_map_pkg::ST_RX_ERR] = rx_err;
		end else if (txlen_hit) begin
			prdata[LEN_W-1:0] = tx_len;
		end else if (rxlen_hit) begin
			prdata[LEN_W-1:0] = rx_len_q;
		end else if (tx_hit) begin
			prdata[7:0] = tx_buf[tx_widx];
		end else if (rx_hit) begin
			prdata[7:0] = rx_buf[rx_ridx];
		end
	end

	apb_enable_in_select: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		penable |-> psel)
		else $error("uart_frame_regs: penable without psel");

endmodule

// File: hdl/uart_frame_ctrl.sv
/*
 * uart frame controller
 * tx sends "&&", the payload from the register block and "&&"
 * rx hunts "&&", stores payload bytes and checks the closing "&&"
 */
`timescale 1ns/1ps
module uart_frame_ctrl #(
	parameter MAX_LEN = 16,
	localparam LEN_W = $clog2(MAX_LEN + 1),
	localparam IDX_W = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire tx_start,
	input wire [LEN_W-1:0] tx_len,
	output reg [IDX_W-1:0] tx_index,
	input wire [7:0] tx_byte,
	output wire tx_busy,
	output reg byte_req,
	output reg [7:0] byte_data,
	input wire byte_done,
	input wire byte_vld,
	input wire [7:0] byte_out,
	output reg rx_we,
	output reg [IDX_W-1:0] rx_index,
	output reg [7:0] rx_byte,
	output reg [LEN_W-1:0] rx_len,
	output reg rx_frame_done,
	output reg rx_frame_err
);

	localparam [1:0] TX_IDLE = 2'd0,
		TX_LEAD = 2'd1,
		TX_BODY = 2'd2,
		TX_TRAIL = 2'd3;

	localparam [1:0] RX_HUNT = 2'd0,
		RX_OPEN = 2'd1,
		RX_BODY = 2'd2,
		RX_CLOSE = 2'd3;

	reg [1:0] tx_state;
	// second delimiter of a pair is on the line
	reg tx_second;
	// tx_index just moved so the buffer byte is ready next cycle
	reg tx_fetch;
	reg [LEN_W-1:0] tx_len_q;
	reg [1:0] rx_state;
	reg [LEN_W-1:0] rx_cnt;
	reg rx_ovf;
	wire is_delim;

	assign tx_busy = (tx_state != TX_IDLE);
	assign is_delim = (byte_out == uart_frame_pkg::DELIM);

	always @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state <= TX_IDLE;
			tx_second <= 1'b0;
			tx_fetch <= 1'b0;
			tx_index <= '0;
			byte_req <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			case (tx_state)
				TX_IDLE: begin
					if (tx_start) begin
						tx_state <= TX_LEAD;
						tx_second <= 1'b0;
						byte_req <= 1'b1;
					end
				end
				TX_LEAD: begin
					if (byte_done && !tx_second) begin
						tx_second <= 1'b1;
						byte_req <= 1'b1;
					end else if (byte_done) begin
						tx_state <= TX_BODY;
						tx_index <= '0;
						tx_fetch <= 1'b1;
					end
				end
				TX_BODY: begin
					if (tx_fetch) begin
						tx_fetch <= 1'b0;
						byte_req <= 1'b1;
					end else if (byte_done && tx_index == tx_len_q - 1'b1) begin
						tx_state <= TX_TRAIL;
						tx_second <= 1'b0;
						byte_req <= 1'b1;
					end else if (byte_done) begin
						tx_index <= tx_index + 1'b1;
						tx_fetch <= 1'b1;
					end
				end
				default: begin
					if (byte_done && !tx_second) begin
						tx_second <= 1'b1;
						byte_req <= 1'b1;
					end else if (byte_done) begin
						tx_state <= TX_IDLE;
					end
				end
			endcase
		end
	end

	// length is held for the whole frame and byte_data is a delimiter unless a payload byte goes out
	always @(posedge sys_clk) begin
		if (tx_state == TX_IDLE && tx_start)
			tx_len_q <= tx_len;
		byte_data <= (tx_state == TX_BODY && tx_fetch) ? tx_byte : uart_frame_pkg::DELIM;
	end

	always @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state <= RX_HUNT;
			rx_cnt <= '0;
			rx_ovf <= 1'b0;
			rx_we <= 1'b0;
			rx_frame_done <= 1'b0;
			rx_frame_err <= 1'b0;
		end else begin
			rx_we <= 1'b0;
			rx_frame_done <= 1'b0;
			rx_frame_err <= 1'b0;
			if (byte_vld) begin
				case (rx_state)
					RX_HUNT: begin
						if (is_delim)
							rx_state <= RX_OPEN;
					end
					RX_OPEN: begin
						rx_cnt <= '0;
						rx_ovf <= 1'b0;
						rx_state <= is_delim ? RX_BODY : RX_HUNT;
					end
					RX_BODY: begin
						if (is_delim) begin
							rx_state <= RX_CLOSE;
						end else if (rx_cnt == MAX_LEN) begin
							// keep reading up to the closing pair and reject there
							rx_ovf <= 1'b1;
						end else begin
							rx_we <= 1'b1;
							rx_cnt <= rx_cnt + 1'b1;
						end
					end
					default: begin
						rx_state <= RX_HUNT;
						if (is_delim && !rx_ovf && rx_cnt != 0)
							rx_frame_done <= 1'b1;
						else
							rx_frame_err <= 1'b1;
					end
				endcase
			end
		end
	end

	always @(posedge sys_clk) begin
		if (byte_vld && rx_state == RX_BODY) begin
			rx_index <= rx_cnt[IDX_W-1:0];
			rx_byte <= byte_out;
		end
		if (byte_vld && rx_state == RX_CLOSE)
			rx_len <= rx_cnt;
	end

	// register block buffer lookup must stay inside the loaded payload
	tx_index_range: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_state == TX_BODY) |-> (tx_index < tx_len_q))
		else $error("uart_frame_ctrl: tx_index beyond tx_len");

	// rx_cnt already counts the byte being written
	rx_index_range: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_we |-> (rx_cnt <= MAX_LEN))
		else $error("uart_frame_ctrl: rx write beyond MAX_LEN");

endmodule

// File: hdl/uart_rx.sv
/*
 * uart_rx
 * 8N1 deserializer, two-flop synchronizer, start confirmed at half a bit
 * byte_vld pulses at mid stop bit, a low stop bit drops the byte
 */
`timescale 1ns/1ps
module uart_rx #(
	parameter CLKS_PER_BIT = 868
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire line,
	output wire [uart_frame_pkg::DATA_BITS-1:0] byte_out,
	output reg byte_vld
);

	localparam HALF_BIT = CLKS_PER_BIT / 2;
	localparam CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam BIT_W = $clog2(uart_frame_pkg::DATA_BITS + 1);

	localparam [1:0] S_IDLE = 2'd0,
		S_START = 2'd1,
		S_DATA = 2'd2,
		S_STOP = 2'd3;

	reg rx_meta;
	reg rx_sync;
	reg [1:0] state;
	reg [CNT_W-1:0] baud_cnt;
	reg [BIT_W-1:0] bit_cnt;
	reg [uart_frame_pkg::DATA_BITS-1:0] shift_reg;
	wire bit_end;

	assign bit_end = (baud_cnt == CLKS_PER_BIT - 1);
	assign byte_out = shift_reg;

	// line is asynchronous to sys_clk
	always @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= line;
			rx_sync <= rx_meta;
		end
	end

	always @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= S_IDLE;
			baud_cnt <= '0;
			bit_cnt <= '0;
			byte_vld <= 1'b0;
		end else begin
			byte_vld <= 1'b0;
			case (state)
				S_IDLE: begin
					baud_cnt <= '0;
					bit_cnt <= '0;
					if (!rx_sync)
						state <= S_START;
				end
				S_START: begin
					if (baud_cnt == HALF_BIT - 1) begin
						baud_cnt <= '0;
						// glitch shorter than half a bit
						state <= rx_sync ? S_IDLE : S_DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == uart_frame_pkg::DATA_BITS - 1)
							state <= S_STOP;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: begin
					if (bit_end) begin
						byte_vld <= rx_sync;
						state <= S_IDLE;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// LSB arrives first
	always @(posedge sys_clk) begin
		if (state == S_DATA && bit_end)
			shift_reg <= {rx_sync, shift_reg[uart_frame_pkg::DATA_BITS-1:1]};
	end

endmodule

// File: hdl/uart_tx.sv
/*
 * uart_tx
 * 8N1 serializer, one byte per request, LSB first
 * byte_done marks the last cycle of the stop bit
 */
`timescale 1ns/1ps
module uart_tx #(
	parameter CLKS_PER_BIT = 868
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire byte_req,
	input wire [uart_frame_pkg::DATA_BITS-1:0] byte_data,
	output wire line,
	output wire byte_done
);

	// start bit, data bits, stop bit
	localparam FRAME_BITS = uart_frame_pkg::DATA_BITS + 2;
	localparam CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam BIT_W = $clog2(FRAME_BITS + 1);

	reg busy;
	reg [CNT_W-1:0] baud_cnt;
	reg [BIT_W-1:0] bit_cnt;
	reg [FRAME_BITS-1:0] shift_reg;
	wire bit_end;

	assign bit_end = (baud_cnt == CLKS_PER_BIT - 1);
	// line comes straight from a flop, idles high
	assign line = shift_reg[0];
	assign byte_done = busy && bit_end && (bit_cnt == FRAME_BITS - 1);

	always @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
			shift_reg <= '1;
		end else if (!busy) begin
			baud_cnt <= '0;
			bit_cnt <= '0;
			if (byte_req) begin
				busy <= 1'b1;
				shift_reg <= {1'b1, byte_data, 1'b0};
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			// ones shift in behind the stop bit
			shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};
			if (bit_cnt == FRAME_BITS - 1)
				busy <= 1'b0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// the frame controller must wait for byte_done
	req_while_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |-> !busy)
		else $error("uart_tx: byte_req while a byte is in flight");

endmodule

// File: hdl/apb_map_pkg.sv
/*
 * apb register map of the frame transceiver
 * byte offsets of the registers and buffers, status bit positions
 */
package apb_map_pkg;

	// address bus width seen by the register block
	localparam int ADDR_W = 8;

	// control and status words
	localparam logic [ADDR_W-1:0] CTRL_OFS = 8'h00;
	localparam logic [ADDR_W-1:0] STATUS_OFS = 8'h04;
	localparam logic [ADDR_W-1:0] TX_LEN_OFS = 8'h08;
	localparam logic [ADDR_W-1:0] RX_LEN_OFS = 8'h0C;

	// buffer windows, one byte per word, room for 16 entries each
	localparam logic [ADDR_W-1:0] TX_BUF_OFS = 8'h40;
	localparam logic [ADDR_W-1:0] RX_BUF_OFS = 8'h80;

	// STATUS bits
	localparam int ST_TX_BUSY = 0;
	localparam int ST_RX_READY = 1;
	localparam int ST_RX_ERR = 2;

endpackage

// File: hdl/uart_frame_pkg.sv
/*
 * uart frame line-side constants
 * character width on the wire and the frame delimiter byte
 */
package uart_frame_pkg;

	// data bits per character, 8N1 on the line
	localparam int DATA_BITS = 8;

	// "&" opens and closes every frame, always sent as a pair
	localparam logic [7:0] DELIM = 8'h26;

endpackage
